// File: build.f
logic/soc_dbg_pkg.sv
logic/apb_per_bridge.sv
logic/dbg_event_rx.sv
logic/dbg_ctrl_regs.sv
logic/soc_debug_domain.sv
tests/soc_debug_checker.sv
tests/tb_soc_debug_domain.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the debug domain testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_soc_debug_domain -f build.f \
  -o tb_sim > "$LOG" 2>&1 && ./obj_dir/tb_sim >> "$LOG" 2>&1
cat "$LOG"

# any reported failure, or a run that never finished, fails the script
grep -q "Test FAILED" "$LOG" && exit 1
grep -q "Test OK" "$LOG" || exit 1
exit 0

// File: tests/tb_soc_debug_domain.sv
/*
  Testbench for the SoC debug domain
  applies a table of APB accesses and event toggles on falling edges
  while the checker module compares the responses
*/
`timescale 1ns/1ps

module tb_soc_debug_domain;
  import soc_dbg_pkg::*;

  localparam int         TIMEOUT = 20;
  localparam logic [1:0] K_WR    = 2'd0;
  localparam logic [1:0] K_RD    = 2'd1;
  localparam logic [1:0] K_EV    = 2'd2;

  // outs is {pready, evt_irq, debug_req, ndmreset, dmactive}
  typedef struct packed {
    logic [1:0] kind;
    addr_t      addr;
    word_t      wdata;
    logic [1:0] ch;
    word_t      exp;
    logic [4:0] outs;
  } stim_t;

  logic       s_soc_clk;
  logic       s_soc_rstn;
  apb_req_t   apb_req;
  word_t      apb_prdata;
  logic       apb_pready;
  evt_vec_t   evt_valid;
  evt_vec_t   evt_ack;
  logic       dmactive;
  logic       ndmreset;
  logic       debug_req;
  logic       evt_irq;
  logic       rd_chk;
  logic       outs_chk;
  logic       ack_chk;
  logic       test_end;
  logic       done;
  logic [1:0] timeout;
  word_t      exp;
  int         test_id;
  int         fail_cnt;
  int         seed;
  stim_t      stim_q [$];

  soc_debug_domain soc_debug_domain_i (
    .s_soc_clk          (s_soc_clk),
    .s_soc_rstn         (s_soc_rstn),
    .apb_req_i          (apb_req),
    .apb_prdata_o       (apb_prdata),
    .apb_pready_o       (apb_pready),
    .pf_evt_valid_i     (evt_valid[EVT_PF]),
    .dma_pe_evt_valid_i (evt_valid[EVT_DMA]),
    .dma_pe_irq_valid_i (evt_valid[EVT_IRQ]),
    .pf_evt_ack_o       (evt_ack[EVT_PF]),
    .dma_pe_evt_ack_o   (evt_ack[EVT_DMA]),
    .dma_pe_irq_ack_o   (evt_ack[EVT_IRQ]),
    .dmactive_o         (dmactive),
    .ndmreset_o         (ndmreset),
    .debug_req_o        (debug_req),
    .evt_irq_o          (evt_irq)
  );

  soc_debug_checker u_checker (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .apb_req_i    (apb_req),
    .apb_prdata_i (apb_prdata),
    .apb_pready_i (apb_pready),
    .ack_i        (evt_ack),
    .outs_i       ({apb_pready, evt_irq, debug_req, ndmreset, dmactive}),
    .rd_chk_i     (rd_chk),
    .outs_chk_i   (outs_chk),
    .ack_chk_i    (ack_chk),
    .timeout_i    (timeout),
    .exp_i        (exp),
    .test_end_i   (test_end),
    .test_id_i    (test_id),
    .done_i       (done),
    .fail_cnt_o   (fail_cnt)
  );

  initial begin
    s_soc_clk = 1'b0;
    forever #2 s_soc_clk = ~s_soc_clk;
  end

  task automatic add_stim(input logic [1:0] kind, input addr_t addr, input word_t wdata,
                          input logic [1:0] ch, input word_t exp_v, input logic [4:0] outs);
    stim_q.push_back('{kind, addr, wdata, ch, exp_v, outs});
  endtask

  // one cycle of check strobes with sel as {ack, outs, rdata}
  task automatic strobe_check(input logic [2:0] sel, input word_t exp_v);
    exp = exp_v;
    {ack_chk, outs_chk, rd_chk} = sel;
    @(negedge s_soc_clk);
    {ack_chk, outs_chk, rd_chk} = 3'b000;
  endtask

  //******************************
  // APB access and event toggle
  //******************************
  task automatic apb_access(input logic we, input addr_t addr, input word_t wdata);
    int cycles;
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: we, pwdata: wdata};
    @(negedge s_soc_clk);
    apb_req.penable = 1'b1;
    cycles = 0;
    do begin
      @(negedge s_soc_clk);
      cycles++;
    end while (!apb_pready && cycles < TIMEOUT);
    timeout = {1'b0, !apb_pready};
    @(negedge s_soc_clk);
    timeout = 2'b00;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic toggle_event(input logic [1:0] ch);
    int cycles;
    evt_valid[ch] = ~evt_valid[ch];
    cycles = 0;
    do begin
      @(negedge s_soc_clk);
      cycles++;
    end while (evt_ack != evt_valid && cycles < TIMEOUT);
    timeout = {evt_ack != evt_valid, 1'b0};
    @(negedge s_soc_clk);
    timeout = 2'b00;
  endtask

  initial begin
    stim_t s;
    word_t rnd0;
    word_t rnd1;
    s_soc_rstn = 1'b0;
    apb_req    = '0;
    evt_valid  = '0;
    {rd_chk, outs_chk, ack_chk, test_end, done} = 5'b00000;
    timeout    = 2'b00;
    exp        = '0;
    test_id    = 0;
    seed       = 32'h9c6a_4ecb;
    rnd0       = $random(seed);
    rnd1       = $random(seed);

    // kind, address, write data, channel, expected read or pending, outputs
    add_stim(K_RD, 32'h00, 32'h0, 2'd0, 32'h0, 5'h00);
    add_stim(K_WR, 32'h00, 32'h7, 2'd0, 32'h0, 5'h07);
    add_stim(K_RD, 32'h00, 32'h0, 2'd0, 32'h7, 5'h07);
    add_stim(K_WR, 32'h00, 32'h1, 2'd0, 32'h0, 5'h01);
    add_stim(K_RD, 32'h00, 32'h0, 2'd0, 32'h1, 5'h01);
    add_stim(K_WR, 32'h08, rnd0, 2'd0, 32'h0, 5'h01);
    add_stim(K_WR, 32'h0C, rnd1, 2'd0, 32'h0, 5'h01);
    add_stim(K_RD, 32'h08, 32'h0, 2'd0, rnd0, 5'h01);
    add_stim(K_RD, 32'h0C, 32'h0, 2'd0, rnd1, 5'h01);
    add_stim(K_RD, 32'h10, 32'h0, 2'd0, 32'h0, 5'h01);
    add_stim(K_EV, 32'h04, 32'h0, 2'd0, 32'h1, 5'h09);
    add_stim(K_EV, 32'h04, 32'h0, 2'd1, 32'h3, 5'h09);
    add_stim(K_EV, 32'h04, 32'h0, 2'd2, 32'h7, 5'h09);
    add_stim(K_WR, 32'h04, 32'h5, 2'd0, 32'h0, 5'h09);
    add_stim(K_RD, 32'h04, 32'h0, 2'd0, 32'h2, 5'h09);
    add_stim(K_WR, 32'h04, 32'h2, 2'd0, 32'h0, 5'h01);
    add_stim(K_RD, 32'h04, 32'h0, 2'd0, 32'h0, 5'h01);
    // falling edge of pf valid is an event too
    add_stim(K_EV, 32'h04, 32'h0, 2'd0, 32'h1, 5'h09);

    repeat (2) @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;
    @(negedge s_soc_clk);

    foreach (stim_q[i]) begin
      s       = stim_q[i];
      test_id = i;
      if (s.kind == K_EV) begin
        toggle_event(s.ch);
      end
      apb_access(s.kind == K_WR, s.addr, s.wdata);
      if (s.kind != K_WR) begin
        strobe_check(3'b001, s.exp);
      end
      strobe_check(3'b010, word_t'(s.outs));
      strobe_check(3'b100, word_t'(evt_valid));
      test_end = 1'b1;
      @(negedge s_soc_clk);
      test_end = 1'b0;
    end

    done = 1'b1;
    @(negedge s_soc_clk);
    done = 1'b0;
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tests/soc_debug_checker.sv
/*
  Debug domain checker
  watches the DUT ports, checks APB wait-state timing on its own and
  compares sampled values against the testbench's expected values
*/
`timescale 1ns/1ps

module soc_debug_checker (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_dbg_pkg::apb_req_t apb_req_i,
  input  soc_dbg_pkg::word_t    apb_prdata_i,
  input  logic                  apb_pready_i,
  input  soc_dbg_pkg::evt_vec_t ack_i,
  input  logic [4:0]            outs_i,
  input  logic                  rd_chk_i,
  input  logic                  outs_chk_i,
  input  logic                  ack_chk_i,
  input  logic [1:0]            timeout_i,
  input  soc_dbg_pkg::word_t    exp_i,
  input  logic                  test_end_i,
  input  int                    test_id_i,
  input  logic                  done_i,
  output int                    fail_cnt_o
);
  import soc_dbg_pkg::*;

  word_t rdata_seen = '0;
  int    acc_cycles = 0;
  int    test_errs  = 0;
  int    pass_cnt   = 0;
  int    fail_cnt   = 0;
  string out_names [5] = '{"dmactive_o", "ndmreset_o", "debug_req_o", "evt_irq_o",
                           "apb_pready_o"};
  string ack_names [3] = '{"pf_evt_ack_o", "dma_pe_evt_ack_o", "dma_pe_irq_ack_o"};

  assign fail_cnt_o = fail_cnt;

  task automatic compare(input string name, input word_t exp_v, input word_t act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp_v, act_v);
      test_errs++;
    end
  endtask

  //******************************
  // sampling of pre-edge values
  //******************************
  always @(posedge s_soc_clk) begin
    if (!s_soc_rstn || !(apb_req_i.psel && apb_req_i.penable)) begin
      acc_cycles = 0;
    end else begin
      acc_cycles++;
    end
    // pready only in the second access-phase cycle
    if (apb_pready_i !== (acc_cycles == 2)) begin
      $display("FAIL apb_pready_o: expected 0x%0h, got 0x%0h in access cycle %0d",
               acc_cycles == 2, apb_pready_i, acc_cycles);
      test_errs++;
    end
    if (apb_pready_i) begin
      rdata_seen = apb_prdata_i;
    end else begin
      compare("apb_prdata_o", '0, apb_prdata_i);
    end

    if (rd_chk_i) begin
      compare("apb_prdata_o", exp_i, rdata_seen);
    end
    if (outs_chk_i) begin
      for (int i = 0; i < 5; i++) begin
        compare(out_names[i], word_t'(exp_i[i]), word_t'(outs_i[i]));
      end
    end
    if (ack_chk_i) begin
      for (int i = 0; i < N_EVT; i++) begin
        compare(ack_names[i], word_t'(exp_i[i]), word_t'(ack_i[i]));
      end
    end
    if (timeout_i[0]) begin
      $display("an APB access got no pready within the timeout");
      test_errs++;
    end
    if (timeout_i[1]) begin
      $display("an event ack did not follow its valid within the timeout");
      test_errs++;
    end

    if (test_end_i) begin
      $display("test %0d: %s", test_id_i, (test_errs == 0) ? "pass" : "fail");
      if (test_errs == 0) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      test_errs = 0;
    end
    if (done_i) begin
      if (test_errs != 0) begin
        $display("checks failed after the last test had finished");
        fail_cnt++;
        test_errs = 0;
      end
      $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    end
  end

endmodule

// File: logic/soc_debug_domain.sv
/*
  SoC debug domain top level
  APB bridge, three event receivers and the debug register block
*/
`timescale 1ns/1ps

module soc_debug_domain (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_dbg_pkg::apb_req_t apb_req_i,
  output soc_dbg_pkg::word_t    apb_prdata_o,
  output logic                  apb_pready_o,
  input  logic                  pf_evt_valid_i,
  input  logic                  dma_pe_evt_valid_i,
  input  logic                  dma_pe_irq_valid_i,
  output logic                  pf_evt_ack_o,
  output logic                  dma_pe_evt_ack_o,
  output logic                  dma_pe_irq_ack_o,
  output logic                  dmactive_o,
  output logic                  ndmreset_o,
  output logic                  debug_req_o,
  output logic                  evt_irq_o
);
  import soc_dbg_pkg::*;

  per_req_t per_req;
  per_rsp_t per_rsp;
  evt_vec_t evt_pulse;

  //******************************
  // APB side
  //******************************
  apb_per_bridge u_bridge (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .apb_req_i    (apb_req_i),
    .per_req_o    (per_req),
    .per_rsp_i    (per_rsp),
    .apb_prdata_o (apb_prdata_o),
    .apb_pready_o (apb_pready_o)
  );

  //******************************
  // event receivers
  //******************************
  dbg_event_rx u_evt_pf (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .valid_i    (pf_evt_valid_i),
    .ack_o      (pf_evt_ack_o),
    .pulse_o    (evt_pulse[EVT_PF])
  );

  dbg_event_rx u_evt_dma (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .valid_i    (dma_pe_evt_valid_i),
    .ack_o      (dma_pe_evt_ack_o),
    .pulse_o    (evt_pulse[EVT_DMA])
  );

  dbg_event_rx u_evt_irq (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .valid_i    (dma_pe_irq_valid_i),
    .ack_o      (dma_pe_irq_ack_o),
    .pulse_o    (evt_pulse[EVT_IRQ])
  );

  // debug registers
  dbg_ctrl_regs u_regs (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .per_req_i   (per_req),
    .per_rsp_o   (per_rsp),
    .evt_pulse_i (evt_pulse),
    .dmactive_o  (dmactive_o),
    .ndmreset_o  (ndmreset_o),
    .debug_req_o (debug_req_o),
    .evt_irq_o   (evt_irq_o)
  );

endmodule

// File: logic/dbg_ctrl_regs.sv
/*
  Debug control register block
  dmcontrol, latched event pending bits and two scratch words
  with read data returned one cycle after each request
*/
`timescale 1ns/1ps

module dbg_ctrl_regs (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_dbg_pkg::per_req_t per_req_i,
  output soc_dbg_pkg::per_rsp_t per_rsp_o,
  input  soc_dbg_pkg::evt_vec_t evt_pulse_i,
  output logic                  dmactive_o,
  output logic                  ndmreset_o,
  output logic                  debug_req_o,
  output logic                  evt_irq_o
);
  import soc_dbg_pkg::*;

  logic [DMCTRL_W-1:0] dmctrl_q;
  evt_vec_t            pending_q;
  evt_vec_t            pending_d;
  evt_vec_t            pending_clr;
  word_t               scratch0_q;
  word_t               scratch1_q;
  word_t               rdata_d;
  word_t               rdata_q;
  logic                r_valid_q;
  logic                irq_q;
  logic                wr_en;
  reg_off_t            offset;

  // byte-wise merge of write data into an old word
  function automatic word_t merge_be(input word_t old_w, input word_t new_w, input be_t be);
    word_t res;
    res = old_w;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign offset = per_req_i.addr[REG_OFF_W-1:0];
  assign wr_en  = per_req_i.req & per_req_i.we;

  //******************************
  // read mux on pre-write values
  //******************************
  always_comb begin
    case (offset)
      REG_DMCONTROL:   rdata_d = word_t'(dmctrl_q);
      REG_EVT_PENDING: rdata_d = word_t'(pending_q);
      REG_SCRATCH0:    rdata_d = scratch0_q;
      REG_SCRATCH1:    rdata_d = scratch1_q;
      default:         rdata_d = '0;
    endcase
  end

  // write-1-clear where a same-cycle event wins
  assign pending_clr = (wr_en && offset == REG_EVT_PENDING && per_req_i.be[0]) ?
                       per_req_i.wdata[N_EVT-1:0] : '0;
  assign pending_d   = (pending_q & ~pending_clr) | evt_pulse_i;

  //******************************
  // control state
  //******************************
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      dmctrl_q  <= '0;
      pending_q <= '0;
      irq_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= per_req_i.req;
      pending_q <= pending_d;
      irq_q     <= |pending_d;
      if (wr_en && offset == REG_DMCONTROL && per_req_i.be[0]) begin
        dmctrl_q <= per_req_i.wdata[DMCTRL_W-1:0];
      end
    end
  end

  // scratch words and read data
  always_ff @(posedge s_soc_clk) begin
    if (wr_en && offset == REG_SCRATCH0) begin
      scratch0_q <= merge_be(scratch0_q, per_req_i.wdata, per_req_i.be);
    end
    if (wr_en && offset == REG_SCRATCH1) begin
      scratch1_q <= merge_be(scratch1_q, per_req_i.wdata, per_req_i.be);
    end
    if (per_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign per_rsp_o = '{r_valid: r_valid_q, rdata: rdata_q};

  assign dmactive_o  = dmctrl_q[DMC_DMACTIVE];
  assign ndmreset_o  = dmctrl_q[DMC_NDMRESET];
  assign debug_req_o = dmctrl_q[DMC_HALTREQ];
  assign evt_irq_o   = irq_q;

endmodule

// File: logic/dbg_event_rx.sv
/*
  Event synchronizer, receive side
  two-flop sync of a toggling valid level, level returned as ack,
  one pulse per level change
*/
`timescale 1ns/1ps

module dbg_event_rx (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic valid_i,
  output logic ack_o,
  output logic pulse_o
);

  logic [1:0] sync_q;
  logic       level_q;

  //******************************
  // synchronizer and edge detect
  //******************************
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      sync_q  <= 2'b00;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
    end
  end

  // sender may toggle again once ack matches its valid
  assign ack_o = sync_q[1];

  // both edges count as an event
  assign pulse_o = sync_q[1] ^ level_q;

endmodule

// File: logic/apb_per_bridge.sv
/*
  APB to peripheral bridge
  turns each APB access phase into a single-cycle request and
  hands the registered response back as pready and prdata
*/
`timescale 1ns/1ps

module apb_per_bridge (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_dbg_pkg::apb_req_t apb_req_i,
  output soc_dbg_pkg::per_req_t per_req_o,
  input  soc_dbg_pkg::per_rsp_t per_rsp_i,
  output soc_dbg_pkg::word_t    apb_prdata_o,
  output logic                  apb_pready_o
);
  import soc_dbg_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          access_phase;
  logic          req_pulse;

  assign access_phase = apb_req_i.psel & apb_req_i.penable;

  //******************************
  // bridge FSM
  //******************************
  always_comb begin
    state_d   = state_q;
    req_pulse = 1'b0;
    case (state_q)
      BR_IDLE: begin
        // request is granted in the cycle it is raised
        if (access_phase) begin
          req_pulse = 1'b1;
          state_d   = BR_WAIT;
        end
      end
      BR_WAIT: begin
        if (per_rsp_i.r_valid) begin
          state_d = BR_IDLE;
        end
      end
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // no strobes on this APB, so full word enables
  assign per_req_o = '{
    req:   req_pulse,
    we:    apb_req_i.pwrite,
    addr:  apb_req_i.paddr,
    wdata: apb_req_i.pwdata,
    be:    {BE_W{1'b1}}
  };

  assign apb_pready_o = (state_q == BR_WAIT) & per_rsp_i.r_valid;
  assign apb_prdata_o = apb_pready_o ? per_rsp_i.rdata : '0;

endmodule

// File: logic/soc_dbg_pkg.sv
/*
  SoC debug domain shared definitions
  widths, debug register map, bus structs and the bridge FSM states
*/
package soc_dbg_pkg;

  // bus widths
  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 32;
  localparam int BE_W      = 4;
  localparam int N_EVT     = 3;
  localparam int REG_OFF_W = 5;
  localparam int DMCTRL_W  = 3;

  // event channel positions in evt_vec_t
  localparam int EVT_PF  = 0;
  localparam int EVT_DMA = 1;
  localparam int EVT_IRQ = 2;

  // dmcontrol bit positions
  localparam int DMC_DMACTIVE = 0;
  localparam int DMC_NDMRESET = 1;
  localparam int DMC_HALTREQ  = 2;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [BE_W-1:0]      be_t;
  typedef logic [N_EVT-1:0]     evt_vec_t;
  typedef logic [REG_OFF_W-1:0] reg_off_t;

  // register map in byte offsets
  localparam reg_off_t REG_DMCONTROL   = 5'h00;
  localparam reg_off_t REG_EVT_PENDING = 5'h04;
  localparam reg_off_t REG_SCRATCH0    = 5'h08;
  localparam reg_off_t REG_SCRATCH1    = 5'h0C;

  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } per_req_t;

  typedef struct packed {
    logic  r_valid;
    word_t rdata;
  } per_rsp_t;

  typedef enum logic {
    BR_IDLE,
    BR_WAIT
  } bridge_state_e;

endpackage
